/* Makefile */
# Verilator build and run of the decode stage testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := tb_id_stage
FILELIST  := sources.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run and search $(LOG) for the pass message"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Test failed, see $(LOG)"; exit 1)
	@echo "Test passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sources.f */
src/id_pkg.sv
src/id_decoder.sv
src/id_operand_mux.sv
src/id_fsm.sv
src/id_regfile.sv
src/id_stage.sv
tb/tb_id_stage.sv

/* src/id_decoder.sv */
// RV32I instruction decoder
// Turns opcode and function fields into register, ALU and LSU controls
// Branch and JAL operands depend on the cycle of the instruction
`timescale 1ns/1ps

module id_decoder #(
  parameter bit RV32E = 1'b0
) (
  input  id_pkg::word_t      instr_rdata_i,
  input  logic               first_cycle_i,
  output logic               illegal_insn_o,
  output logic               rf_we_o,
  output logic               rf_ren_a_o,
  output logic               rf_ren_b_o,
  output id_pkg::reg_addr_t  rf_raddr_a_o,
  output id_pkg::reg_addr_t  rf_raddr_b_o,
  output id_pkg::reg_addr_t  rf_waddr_o,
  output id_pkg::imm_b_sel_e imm_b_sel_o,
  output id_pkg::op_a_sel_e  op_a_sel_o,
  output id_pkg::op_b_sel_e  op_b_sel_o,
  output id_pkg::alu_op_e    alu_operator_o,
  output logic               lsu_req_o,
  output logic               lsu_we_o,
  output logic               lsu_sign_ext_o,
  output id_pkg::lsu_type_e  lsu_type_o,
  output logic               branch_o,
  output logic               jump_o
);

  import id_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       illegal_enc;
  logic       illegal_reg;

  // Size field shared by loads and stores
  function automatic lsu_type_e lsu_size(input logic [1:0] size);
    lsu_type_e kind;
    unique case (size)
      2'b00:   kind = LSU_BYTE;
      2'b01:   kind = LSU_HALF;
      default: kind = LSU_WORD;
    endcase
    return kind;
  endfunction

  assign opcode = instr_rdata_i[6:0];
  assign funct3 = instr_rdata_i[14:12];
  assign funct7 = instr_rdata_i[31:25];

  // Register indices sit in fixed fields for every format
  assign rf_raddr_a_o = instr_rdata_i[19:15];
  assign rf_raddr_b_o = instr_rdata_i[24:20];
  assign rf_waddr_o   = instr_rdata_i[11:7];

  //////////////////////////////////////////////////////////////////////////
  // Control decode
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    illegal_enc    = 1'b0;
    rf_we_o        = 1'b0;
    rf_ren_a_o     = 1'b0;
    rf_ren_b_o     = 1'b0;
    imm_b_sel_o    = IMM_B_I;
    op_a_sel_o     = OP_A_REG_A;
    op_b_sel_o     = OP_B_IMM;
    alu_operator_o = ALU_ADD;
    lsu_req_o      = 1'b0;
    lsu_we_o       = 1'b0;
    lsu_sign_ext_o = 1'b0;
    lsu_type_o     = LSU_WORD;
    branch_o       = 1'b0;
    jump_o         = 1'b0;

    unique case (opcode)
      OPCODE_LUI: begin
        // Zero plus U-immediate
        op_a_sel_o  = OP_A_ZERO;
        imm_b_sel_o = IMM_B_U;
        rf_we_o     = 1'b1;
      end
      OPCODE_AUIPC: begin
        op_a_sel_o  = OP_A_CURRPC;
        imm_b_sel_o = IMM_B_U;
        rf_we_o     = 1'b1;
      end
      OPCODE_JAL: begin
        // Target first, link value PC+4 in the second cycle
        jump_o      = 1'b1;
        rf_we_o     = 1'b1;
        op_a_sel_o  = OP_A_CURRPC;
        imm_b_sel_o = first_cycle_i ? IMM_B_J : IMM_B_INCR_PC;
      end
      OPCODE_BRANCH: begin
        branch_o   = 1'b1;
        rf_ren_a_o = 1'b1;
        rf_ren_b_o = 1'b1;
        if (first_cycle_i) begin
          // Compare rs1 against rs2
          op_b_sel_o = OP_B_REG_B;
          unique case (funct3)
            3'b000:  alu_operator_o = ALU_EQ;
            3'b001:  alu_operator_o = ALU_NE;
            3'b100:  alu_operator_o = ALU_LT;
            3'b101:  alu_operator_o = ALU_GE;
            3'b110:  alu_operator_o = ALU_LTU;
            3'b111:  alu_operator_o = ALU_GEU;
            default: illegal_enc    = 1'b1;
          endcase
        end else begin
          // Taken, so add PC and the B-immediate
          op_a_sel_o  = OP_A_CURRPC;
          imm_b_sel_o = IMM_B_B;
        end
      end
      OPCODE_LOAD: begin
        lsu_req_o      = 1'b1;
        rf_ren_a_o     = 1'b1;
        rf_we_o        = 1'b1;
        lsu_type_o     = lsu_size(funct3[1:0]);
        lsu_sign_ext_o = ~funct3[2];
        // No LD, LWU or unsigned-word forms
        illegal_enc    = (funct3[1:0] == 2'b11) | (funct3[2] & funct3[1]);
      end
      OPCODE_STORE: begin
        lsu_req_o   = 1'b1;
        lsu_we_o    = 1'b1;
        rf_ren_a_o  = 1'b1;
        rf_ren_b_o  = 1'b1;
        imm_b_sel_o = IMM_B_S;
        lsu_type_o  = lsu_size(funct3[1:0]);
        illegal_enc = funct3[2] | (funct3[1:0] == 2'b11);
      end
      OPCODE_OP_IMM: begin
        rf_ren_a_o = 1'b1;
        rf_we_o    = 1'b1;
        unique case (funct3)
          3'b000: alu_operator_o = ALU_ADD;
          3'b010: alu_operator_o = ALU_SLT;
          3'b011: alu_operator_o = ALU_SLTU;
          3'b100: alu_operator_o = ALU_XOR;
          3'b110: alu_operator_o = ALU_OR;
          3'b111: alu_operator_o = ALU_AND;
          3'b001: begin
            alu_operator_o = ALU_SLL;
            illegal_enc    = (funct7 != 7'b0000000);
          end
          default: begin
            // Shift right, funct7 picks logical or arithmetic
            alu_operator_o = funct7[5] ? ALU_SRA : ALU_SRL;
            illegal_enc    = ({funct7[6], funct7[4:0]} != 6'b0);
          end
        endcase
      end
      OPCODE_OP: begin
        rf_ren_a_o = 1'b1;
        rf_ren_b_o = 1'b1;
        rf_we_o    = 1'b1;
        op_b_sel_o = OP_B_REG_B;
        unique case ({funct7, funct3})
          10'b0000000_000: alu_operator_o = ALU_ADD;
          10'b0100000_000: alu_operator_o = ALU_SUB;
          10'b0000000_001: alu_operator_o = ALU_SLL;
          10'b0000000_010: alu_operator_o = ALU_SLT;
          10'b0000000_011: alu_operator_o = ALU_SLTU;
          10'b0000000_100: alu_operator_o = ALU_XOR;
          10'b0000000_101: alu_operator_o = ALU_SRL;
          10'b0100000_101: alu_operator_o = ALU_SRA;
          10'b0000000_110: alu_operator_o = ALU_OR;
          10'b0000000_111: alu_operator_o = ALU_AND;
          default:         illegal_enc    = 1'b1;
        endcase
      end
      default: illegal_enc = 1'b1;
    endcase
  end

  // RV32E only has x0 to x15
  assign illegal_reg = RV32E & ((rf_ren_a_o & rf_raddr_a_o[REG_ADDR_W-1]) |
                                (rf_ren_b_o & rf_raddr_b_o[REG_ADDR_W-1]) |
                                (rf_we_o & rf_waddr_o[REG_ADDR_W-1]));

  assign illegal_insn_o = illegal_enc | illegal_reg;

  // The FSM relies on a single multi-cycle class per instruction
  always_comb begin
    assert ($onehot0({lsu_req_o, branch_o, jump_o}))
      else $error("Decoder raised more than one multi-cycle class");
  end

endmodule

/* src/id_fsm.sv */
// Decode stage controller
// FIRST_CYCLE / MULTI_CYCLE sequencing of loads, stores, branches and JAL
// Generates done, PC set, LSU request and the final register write enable
`timescale 1ns/1ps

module id_fsm (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic instr_valid_i,
  input  logic illegal_insn_i,
  input  logic lsu_req_dec_i,
  input  logic branch_i,
  input  logic jump_i,
  input  logic rf_we_dec_i,
  input  logic branch_decision_i,
  input  logic lsu_resp_valid_i,
  output logic first_cycle_o,
  output logic instr_done_o,
  output logic lsu_req_o,
  output logic pc_set_o,
  output logic rf_we_o
);

  typedef enum logic {
    FIRST_CYCLE,
    MULTI_CYCLE
  } id_fsm_e;

  id_fsm_e state_q;
  id_fsm_e state_d;
  logic    legal;

  assign legal         = instr_valid_i & ~illegal_insn_i;
  assign first_cycle_o = instr_valid_i & (state_q == FIRST_CYCLE);

  // One request per access, only in its first cycle
  assign lsu_req_o = first_cycle_o & legal & lsu_req_dec_i;

  //////////////////////////////////////////////////////////////////////////
  // Next state and outputs
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    instr_done_o = 1'b0;
    pc_set_o     = 1'b0;
    rf_we_o      = 1'b0;

    if (instr_valid_i) begin
      unique case (state_q)
        FIRST_CYCLE: begin
          if (!legal) begin
            // Illegal retires at once without side effects
            instr_done_o = 1'b1;
          end else if (lsu_req_dec_i) begin
            state_d = MULTI_CYCLE;
          end else if (branch_i) begin
            // Target computed next cycle only when taken
            if (branch_decision_i) begin
              state_d = MULTI_CYCLE;
            end else begin
              instr_done_o = 1'b1;
            end
          end else if (jump_i) begin
            // Jump target on result_ex_i now, link written later
            pc_set_o = 1'b1;
            state_d  = MULTI_CYCLE;
          end else begin
            instr_done_o = 1'b1;
            rf_we_o      = rf_we_dec_i;
          end
        end
        MULTI_CYCLE: begin
          if (lsu_req_dec_i) begin
            // Wait for the LSU, load data on result_ex_i
            if (lsu_resp_valid_i) begin
              instr_done_o = 1'b1;
              rf_we_o      = rf_we_dec_i & legal;
              state_d      = FIRST_CYCLE;
            end
          end else begin
            // Branch target or JAL link cycle
            instr_done_o = 1'b1;
            pc_set_o     = branch_i;
            rf_we_o      = jump_i & rf_we_dec_i & legal;
            state_d      = FIRST_CYCLE;
          end
        end
        default: state_d = FIRST_CYCLE;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= FIRST_CYCLE;
    end else begin
      state_q <= state_d;
    end
  end

  // A finished instruction never leaves the FSM in MULTI_CYCLE
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_done_o |=> (state_q == FIRST_CYCLE))
    else $error("Instruction done while entering MULTI_CYCLE");

  // Request is a single pulse, the access then waits in MULTI_CYCLE
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    lsu_req_o |=> !lsu_req_o)
    else $error("LSU request held past the first cycle");

endmodule

/* src/id_operand_mux.sv */
// ALU operand selection
// Builds the immediate of the selected kind and picks operands A and B
`timescale 1ns/1ps

module id_operand_mux (
  input  id_pkg::op_a_sel_e  op_a_sel_i,
  input  id_pkg::op_b_sel_e  op_b_sel_i,
  input  id_pkg::imm_b_sel_e imm_b_sel_i,
  input  id_pkg::word_t      instr_rdata_i,
  input  id_pkg::word_t      rf_rdata_a_i,
  input  id_pkg::word_t      rf_rdata_b_i,
  input  id_pkg::word_t      pc_id_i,
  output id_pkg::word_t      alu_operand_a_o,
  output id_pkg::word_t      alu_operand_b_o
);

  import id_pkg::*;

  word_t imm_b;

  //////////////////////////////////////////////////////////////////////////
  // Immediates
  //////////////////////////////////////////////////////////////////////////

  // All kinds are sign extended from bit 31
  always_comb begin
    unique case (imm_b_sel_i)
      IMM_B_I: imm_b = {{20{instr_rdata_i[31]}}, instr_rdata_i[31:20]};
      IMM_B_S: imm_b = {{20{instr_rdata_i[31]}}, instr_rdata_i[31:25], instr_rdata_i[11:7]};
      // Branch offset, second cycle of a taken branch
      IMM_B_B: imm_b = {{19{instr_rdata_i[31]}}, instr_rdata_i[31], instr_rdata_i[7],
                        instr_rdata_i[30:25], instr_rdata_i[11:8], 1'b0};
      IMM_B_U: imm_b = {instr_rdata_i[31:12], 12'b0};
      IMM_B_J: imm_b = {{12{instr_rdata_i[31]}}, instr_rdata_i[19:12], instr_rdata_i[20],
                        instr_rdata_i[30:21], 1'b0};
      default: imm_b = 32'd4;
    endcase
  end

  //////////////////////////////////////////////////////////////////////////
  // Operands
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (op_a_sel_i)
      OP_A_REG_A:  alu_operand_a_o = rf_rdata_a_i;
      OP_A_CURRPC: alu_operand_a_o = pc_id_i;
      default:     alu_operand_a_o = '0;
    endcase
  end

  assign alu_operand_b_o = (op_b_sel_i == OP_B_IMM) ? imm_b : rf_rdata_b_i;

  // Selects come from the decoder and must never float
  always_comb begin
    assert (!$isunknown({op_a_sel_i, op_b_sel_i}))
      else $error("Operand select unknown");
    if (op_b_sel_i == OP_B_IMM) begin
      assert (!$isunknown(imm_b_sel_i))
        else $error("Immediate select unknown while immediate in use");
    end
  end

endmodule

/* src/id_pkg.sv */
// Decode stage shared definitions
// Widths, kept RV32I major opcodes, ALU operators and operand select codes
package id_pkg;

  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;

  typedef logic [XLEN-1:0]       word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // Major opcodes handled by the stage, everything else is illegal
  typedef enum logic [6:0] {
    OPCODE_OP     = 7'h33,
    OPCODE_OP_IMM = 7'h13,
    OPCODE_LUI    = 7'h37,
    OPCODE_AUIPC  = 7'h17,
    OPCODE_LOAD   = 7'h03,
    OPCODE_STORE  = 7'h23,
    OPCODE_BRANCH = 7'h63,
    OPCODE_JAL    = 7'h6f
  } opcode_e;

  typedef enum logic [3:0] {
    // Arithmetic and logic
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
    // Branch comparisons
    ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  // Operand A source, ZERO serves LUI
  typedef enum logic [1:0] {
    OP_A_REG_A,
    OP_A_CURRPC,
    OP_A_ZERO
  } op_a_sel_e;

  typedef enum logic {
    OP_B_REG_B,
    OP_B_IMM
  } op_b_sel_e;

  // Immediate kind, INCR_PC is the constant 4 for the link value
  typedef enum logic [2:0] {
    IMM_B_I, IMM_B_S, IMM_B_B, IMM_B_U, IMM_B_J, IMM_B_INCR_PC
  } imm_b_sel_e;

  // Access size as seen by the LSU
  typedef enum logic [1:0] {
    LSU_WORD = 2'b00,
    LSU_HALF = 2'b01,
    LSU_BYTE = 2'b10
  } lsu_type_e;

endpackage

/* src/id_regfile.sv */
// Integer register file
// Two combinational read ports, one write port, x0 reads as zero
`timescale 1ns/1ps

module id_regfile #(
  parameter bit RV32E = 1'b0
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  id_pkg::reg_addr_t raddr_a_i,
  input  id_pkg::reg_addr_t raddr_b_i,
  input  id_pkg::reg_addr_t waddr_i,
  input  id_pkg::word_t     wdata_i,
  input  logic              we_i,
  output id_pkg::word_t     rdata_a_o,
  output id_pkg::word_t     rdata_b_o
);

  import id_pkg::*;

  // RV32E halves the file
  localparam int unsigned ADDR_W    = RV32E ? 4 : 5;
  localparam int unsigned NUM_WORDS = 2 ** ADDR_W;

  word_t             mem_q [NUM_WORDS];
  logic [ADDR_W-1:0] raddr_a_idx;
  logic [ADDR_W-1:0] raddr_b_idx;
  logic [ADDR_W-1:0] waddr_idx;

  assign raddr_a_idx = raddr_a_i[ADDR_W-1:0];
  assign raddr_b_idx = raddr_b_i[ADDR_W-1:0];
  assign waddr_idx   = waddr_i[ADDR_W-1:0];

  // Entry 0 is never written, so it stays at its reset value of zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_q <= '{default: '0};
    end else if (we_i && (waddr_idx != '0)) begin
      mem_q[waddr_idx] <= wdata_i;
    end
  end

  assign rdata_a_o = mem_q[raddr_a_idx];
  assign rdata_b_o = mem_q[raddr_b_idx];

endmodule

/* src/id_stage.sv */
// Instruction decode stage of a non-pipelined RV32I core
// Decoder, operand selection, controller and integer register file
`timescale 1ns/1ps

module id_stage #(
  parameter bit RV32E = 1'b0
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  // Fetch handshake
  input  logic              instr_valid_i,
  input  id_pkg::word_t     instr_rdata_i,
  input  id_pkg::word_t     pc_id_i,
  output logic              id_in_ready_o,
  output logic              illegal_insn_o,
  // EX interface
  input  logic              branch_decision_i,
  input  id_pkg::word_t     result_ex_i,
  output logic              pc_set_o,
  output id_pkg::alu_op_e   alu_operator_o,
  output id_pkg::word_t     alu_operand_a_o,
  output id_pkg::word_t     alu_operand_b_o,
  // LSU request/response
  output logic              lsu_req_o,
  output logic              lsu_we_o,
  output id_pkg::lsu_type_e lsu_type_o,
  output logic              lsu_sign_ext_o,
  output id_pkg::word_t     lsu_wdata_o,
  input  logic              lsu_resp_valid_i
);

  import id_pkg::*;

  logic       first_cycle;
  logic       rf_we_dec;
  logic       rf_we;
  reg_addr_t  rf_raddr_a;
  reg_addr_t  rf_raddr_b;
  reg_addr_t  rf_waddr;
  word_t      rf_rdata_a;
  word_t      rf_rdata_b;
  imm_b_sel_e imm_b_sel;
  op_a_sel_e  op_a_sel;
  op_b_sel_e  op_b_sel;
  logic       lsu_req_dec;
  logic       branch;
  logic       jump;

  id_decoder #(
    .RV32E (RV32E)
  ) decoder_i (
    .instr_rdata_i  (instr_rdata_i),
    .first_cycle_i  (first_cycle),
    .illegal_insn_o (illegal_insn_o),
    .rf_we_o        (rf_we_dec),
    .rf_ren_a_o     (),
    .rf_ren_b_o     (),
    .rf_raddr_a_o   (rf_raddr_a),
    .rf_raddr_b_o   (rf_raddr_b),
    .rf_waddr_o     (rf_waddr),
    .imm_b_sel_o    (imm_b_sel),
    .op_a_sel_o     (op_a_sel),
    .op_b_sel_o     (op_b_sel),
    .alu_operator_o (alu_operator_o),
    .lsu_req_o      (lsu_req_dec),
    .lsu_we_o       (lsu_we_o),
    .lsu_sign_ext_o (lsu_sign_ext_o),
    .lsu_type_o     (lsu_type_o),
    .branch_o       (branch),
    .jump_o         (jump)
  );

  id_operand_mux operand_mux_i (
    .op_a_sel_i      (op_a_sel),
    .op_b_sel_i      (op_b_sel),
    .imm_b_sel_i     (imm_b_sel),
    .instr_rdata_i   (instr_rdata_i),
    .rf_rdata_a_i    (rf_rdata_a),
    .rf_rdata_b_i    (rf_rdata_b),
    .pc_id_i         (pc_id_i),
    .alu_operand_a_o (alu_operand_a_o),
    .alu_operand_b_o (alu_operand_b_o)
  );

  id_fsm fsm_i (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .instr_valid_i     (instr_valid_i),
    .illegal_insn_i    (illegal_insn_o),
    .lsu_req_dec_i     (lsu_req_dec),
    .branch_i          (branch),
    .jump_i            (jump),
    .rf_we_dec_i       (rf_we_dec),
    .branch_decision_i (branch_decision_i),
    .lsu_resp_valid_i  (lsu_resp_valid_i),
    .first_cycle_o     (first_cycle),
    .instr_done_o      (id_in_ready_o),
    .lsu_req_o         (lsu_req_o),
    .pc_set_o          (pc_set_o),
    .rf_we_o           (rf_we)
  );

  // Writeback always takes the EX result, load data included
  id_regfile #(
    .RV32E (RV32E)
  ) regfile_i (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (rf_raddr_a),
    .raddr_b_i (rf_raddr_b),
    .waddr_i   (rf_waddr),
    .wdata_i   (result_ex_i),
    .we_i      (rf_we),
    .rdata_a_o (rf_rdata_a),
    .rdata_b_o (rf_rdata_b)
  );

  // Store data is rs2
  assign lsu_wdata_o = rf_rdata_b;

endmodule

/* tb/tb_id_stage.sv */
// Directed testbench for the instruction decode stage
// Plays fetch, EX and LSU around the DUT and checks each instruction class
`timescale 1ns/1ps

module tb_id_stage;

  import id_pkg::*;

  localparam int unsigned TIMEOUT_CYCLES = 20;

  logic      clk_i;
  logic      rst_ni;
  logic      instr_valid_i;
  word_t     instr_rdata_i;
  word_t     pc_id_i;
  logic      id_in_ready_o;
  logic      illegal_insn_o;
  logic      branch_decision_i;
  word_t     result_ex_i;
  logic      pc_set_o;
  alu_op_e   alu_operator_o;
  word_t     alu_operand_a_o;
  word_t     alu_operand_b_o;
  logic      lsu_req_o;
  logic      lsu_we_o;
  lsu_type_e lsu_type_o;
  logic      lsu_sign_ext_o;
  word_t     lsu_wdata_o;
  logic      lsu_resp_valid_i;

  word_t       lfsr_q;
  int unsigned error_count;

  id_stage #(
    .RV32E (1'b0)
  ) id_stage_i (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .instr_valid_i     (instr_valid_i),
    .instr_rdata_i     (instr_rdata_i),
    .pc_id_i           (pc_id_i),
    .id_in_ready_o     (id_in_ready_o),
    .illegal_insn_o    (illegal_insn_o),
    .branch_decision_i (branch_decision_i),
    .result_ex_i       (result_ex_i),
    .pc_set_o          (pc_set_o),
    .alu_operator_o    (alu_operator_o),
    .alu_operand_a_o   (alu_operand_a_o),
    .alu_operand_b_o   (alu_operand_b_o),
    .lsu_req_o         (lsu_req_o),
    .lsu_we_o          (lsu_we_o),
    .lsu_type_o        (lsu_type_o),
    .lsu_sign_ext_o    (lsu_sign_ext_o),
    .lsu_wdata_o       (lsu_wdata_o),
    .lsu_resp_valid_i  (lsu_resp_valid_i)
  );

  // 20 ns period
  always #10 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  // Galois LFSR, taps for x^32 + x^22 + x^2 + x + 1
  function automatic word_t lfsr_step(input word_t state);
    word_t next;
    next = state >> 1;
    if (state[0]) begin
      next = next ^ 32'h8020_0003;
    end
    return next;
  endfunction

  // One LFSR step per bit taken
  task automatic rand_word(output word_t value);
    for (int i = 0; i < 32; i++) begin
      value[i] = lfsr_q[0];
      lfsr_q   = lfsr_step(lfsr_q);
    end
  endtask

  // Instruction formats as laid out in the RISC-V base spec
  function automatic word_t i_type_word(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] funct3, input logic [4:0] rd,
                                        input logic [6:0] opcode);
    return {imm, rs1, funct3, rd, opcode};
  endfunction

  function automatic word_t r_type_word(input logic [6:0] funct7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] funct3,
                                        input logic [4:0] rd);
    return {funct7, rs2, rs1, funct3, rd, 7'h33};
  endfunction

  function automatic word_t s_type_word(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] funct3);
    return {imm[11:5], rs2, rs1, funct3, imm[4:0], 7'h23};
  endfunction

  // Offset bit 0 is implied zero
  function automatic word_t b_type_word(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] funct3);
    return {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic word_t j_type_word(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  task automatic stop_with_failure(input string reason);
    error_count++;
    $display("%s", reason);
    $display("Simulation finished: FAIL");
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic check_value(input string name, input word_t actual, input word_t expected);
    if (actual !== expected) begin
      stop_with_failure($sformatf("Mismatch at time %0t: %s is 0x%08h, expected 0x%08h",
                                  $time, name, actual, expected));
    end
  endtask

  // Present one instruction at the falling edge, then let the outputs settle
  task automatic issue(input word_t instr, input word_t pc, input word_t result,
                       input logic taken);
    @(negedge clk_i);
    instr_valid_i     = 1'b1;
    instr_rdata_i     = instr;
    pc_id_i           = pc;
    result_ex_i       = result;
    branch_decision_i = taken;
    lsu_resp_valid_i  = 1'b0;
    #1;
  endtask

  // Hold the instruction for another cycle with new EX and LSU values
  task automatic advance_cycle(input word_t result, input logic resp);
    @(negedge clk_i);
    result_ex_i      = result;
    lsu_resp_valid_i = resp;
    #1;
  endtask

  task automatic wait_ready(input int unsigned max_cycles);
    int unsigned cycles;
    cycles = 0;
    while (id_in_ready_o !== 1'b1) begin
      if (cycles >= max_cycles) begin
        stop_with_failure("Timeout while waiting for id_in_ready_o");
      end
      @(negedge clk_i);
      #1;
      cycles++;
    end
  endtask

  // ADDI rd, x0, 0 with the value supplied as the EX result
  task automatic write_reg(input logic [4:0] rd, input word_t value);
    issue(i_type_word(12'h000, 5'd0, 3'b000, rd, 7'h13), 32'h0000_0100, value, 1'b0);
    wait_ready(TIMEOUT_CYCLES);
  endtask

  // ADD x0, rs, x0 puts the register on operand A
  task automatic read_reg(input logic [4:0] rs, input word_t expected);
    issue(r_type_word(7'h00, 5'd0, rs, 3'b000, 5'd0), 32'h0000_0104, 32'h0, 1'b0);
    check_value($sformatf("x%0d on alu_operand_a_o", rs), alu_operand_a_o, expected);
    check_value("illegal_insn_o", 32'(illegal_insn_o), 32'h0);
    wait_ready(TIMEOUT_CYCLES);
  endtask

  task automatic apply_reset();
    rst_ni = 1'b0;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    #1;
    check_value("lsu_req_o", 32'(lsu_req_o), 32'h0);
    check_value("pc_set_o", 32'(pc_set_o), 32'h0);
    check_value("id_in_ready_o", 32'(id_in_ready_o), 32'h0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic write_read_back();
    word_t value;
    rand_word(value);
    // ADDI x5, x0, -0x75b
    issue(i_type_word(12'h8a5, 5'd0, 3'b000, 5'd5, 7'h13), 32'h0000_0200, value, 1'b0);
    check_value("alu_operand_a_o", alu_operand_a_o, 32'h0);
    check_value("alu_operand_b_o", alu_operand_b_o, 32'hffff_f8a5);
    check_value("alu_operator_o", 32'(alu_operator_o), 32'(ALU_ADD));
    check_value("id_in_ready_o", 32'(id_in_ready_o), 32'h1);
    wait_ready(TIMEOUT_CYCLES);
    // ADD x6, x5, x0
    issue(r_type_word(7'h00, 5'd0, 5'd5, 3'b000, 5'd6), 32'h0000_0204, value, 1'b0);
    check_value("alu_operand_a_o", alu_operand_a_o, value);
    check_value("alu_operand_b_o", alu_operand_b_o, 32'h0);
    check_value("alu_operator_o", 32'(alu_operator_o), 32'(ALU_ADD));
    wait_ready(TIMEOUT_CYCLES);
  endtask

  task automatic zero_register();
    word_t value;
    rand_word(value);
    // Nonzero EX result aimed at x0
    issue(i_type_word(12'h123, 5'd0, 3'b000, 5'd0, 7'h13), 32'h0000_0210, value | 32'h1,
          1'b0);
    wait_ready(TIMEOUT_CYCLES);
    // OR x7, x0, x0
    issue(r_type_word(7'h00, 5'd0, 5'd0, 3'b110, 5'd7), 32'h0000_0214, 32'h0, 1'b0);
    check_value("alu_operand_a_o", alu_operand_a_o, 32'h0);
    check_value("alu_operand_b_o", alu_operand_b_o, 32'h0);
    check_value("alu_operator_o", 32'(alu_operator_o), 32'(ALU_OR));
    wait_ready(TIMEOUT_CYCLES);
  endtask

  // Load from 0x10(x8), response after delay cycles
  task automatic load_access(input logic [2:0] funct3, input logic [4:0] rd, input word_t base,
                             input lsu_type_e size, input logic sign_ext,
                             input int unsigned delay);
    word_t data;
    rand_word(data);
    issue(i_type_word(12'h010, 5'd8, funct3, rd, 7'h03), 32'h0000_0300, 32'h0, 1'b0);
    check_value("lsu_req_o", 32'(lsu_req_o), 32'h1);
    check_value("lsu_we_o", 32'(lsu_we_o), 32'h0);
    check_value("lsu_type_o", 32'(lsu_type_o), 32'(size));
    check_value("lsu_sign_ext_o", 32'(lsu_sign_ext_o), 32'(sign_ext));
    check_value("alu_operand_a_o", alu_operand_a_o, base);
    check_value("alu_operand_b_o", alu_operand_b_o, 32'h10);
    check_value("id_in_ready_o", 32'(id_in_ready_o), 32'h0);
    // LSU busy, request gone and stage stalled
    repeat (delay - 1) begin
      advance_cycle(32'h0, 1'b0);
      check_value("lsu_req_o", 32'(lsu_req_o), 32'h0);
      check_value("id_in_ready_o", 32'(id_in_ready_o), 32'h0);
    end
    // Load data rides on the EX result
    advance_cycle(data, 1'b1);
    check_value("lsu_req_o", 32'(lsu_req_o), 32'h0);
    check_value("id_in_ready_o", 32'(id_in_ready_o), 32'h1);
    wait_ready(TIMEOUT_CYCLES);
    read_reg(rd, data);
  endtask

  task automatic store_access(input word_t base, input int unsigned delay);
    word_t data;
    rand_word(data);
    write_reg(5'd10, data);
    // SW x10, 0x24(x8)
    issue(s_type_word(12'h024, 5'd10, 5'd8, 3'b010), 32'h0000_0320, 32'h0, 1'b0);
    check_value("lsu_req_o", 32'(lsu_req_o), 32'h1);
    check_value("lsu_we_o", 32'(lsu_we_o), 32'h1);
    check_value("lsu_type_o", 32'(lsu_type_o), 32'(LSU_WORD));
    check_value("lsu_wdata_o", lsu_wdata_o, data);
    check_value("alu_operand_a_o", alu_operand_a_o, base);
    check_value("alu_operand_b_o", alu_operand_b_o, 32'h24);
    check_value("id_in_ready_o", 32'(id_in_ready_o), 32'h0);
    repeat (delay - 1) begin
      advance_cycle(32'h0, 1'b0);
      check_value("id_in_ready_o", 32'(id_in_ready_o), 32'h0);
    end
    advance_cycle(32'h0, 1'b1);
    check_value("id_in_ready_o", 32'(id_in_ready_o), 32'h1);
    wait_ready(TIMEOUT_CYCLES);
  endtask

  task automatic load_store_stall();
    word_t base;
    rand_word(base);
    write_reg(5'd8, base);
    load_access(3'b000, 5'd9, base, LSU_BYTE, 1'b1, 1);
    load_access(3'b101, 5'd9, base, LSU_HALF, 1'b0, 3);
    load_access(3'b010, 5'd12, base, LSU_WORD, 1'b1, 5);
    store_access(base, 2);
  endtask

  task automatic branch_sequence();
    word_t a;
    word_t b;
    rand_word(a);
    rand_word(b);
    write_reg(5'd11, a);
    write_reg(5'd12, b);
    // BEQ x11, x12, +0x20, not taken
    issue(b_type_word(13'h0020, 5'd12, 5'd11, 3'b000), 32'h0000_0400, 32'h0, 1'b0);
    check_value("alu_operator_o", 32'(alu_operator_o), 32'(ALU_EQ));
    check_value("alu_operand_a_o", alu_operand_a_o, a);
    check_value("alu_operand_b_o", alu_operand_b_o, b);
    check_value("id_in_ready_o", 32'(id_in_ready_o), 32'h1);
    check_value("pc_set_o", 32'(pc_set_o), 32'h0);
    wait_ready(TIMEOUT_CYCLES);
    // BNE x11, x12, -0x40, taken
    issue(b_type_word(13'h1fc0, 5'd12, 5'd11, 3'b001), 32'h0000_1000, 32'h0, 1'b1);
    check_value("alu_operator_o", 32'(alu_operator_o), 32'(ALU_NE));
    check_value("id_in_ready_o", 32'(id_in_ready_o), 32'h0);
    check_value("pc_set_o", 32'(pc_set_o), 32'h0);
    // Target cycle, EX returns PC + offset
    advance_cycle(32'h0000_0fc0, 1'b0);
    check_value("alu_operand_a_o", alu_operand_a_o, 32'h0000_1000);
    check_value("alu_operand_b_o", alu_operand_b_o, 32'hffff_ffc0);
    check_value("alu_operator_o", 32'(alu_operator_o), 32'(ALU_ADD));
    check_value("pc_set_o", 32'(pc_set_o), 32'h1);
    check_value("id_in_ready_o", 32'(id_in_ready_o), 32'h1);
    wait_ready(TIMEOUT_CYCLES);
  endtask

  task automatic jal_link();
    // JAL x13, -0x1000
    issue(j_type_word(21'h1f_f000, 5'd13), 32'h0000_2000, 32'h0000_1000, 1'b0);
    check_value("pc_set_o", 32'(pc_set_o), 32'h1);
    check_value("alu_operand_a_o", alu_operand_a_o, 32'h0000_2000);
    check_value("alu_operand_b_o", alu_operand_b_o, 32'hffff_f000);
    check_value("alu_operator_o", 32'(alu_operator_o), 32'(ALU_ADD));
    check_value("id_in_ready_o", 32'(id_in_ready_o), 32'h0);
    // Link cycle, EX returns PC + 4
    advance_cycle(32'h0000_2004, 1'b0);
    check_value("alu_operand_a_o", alu_operand_a_o, 32'h0000_2000);
    check_value("alu_operand_b_o", alu_operand_b_o, 32'h4);
    check_value("alu_operator_o", 32'(alu_operator_o), 32'(ALU_ADD));
    check_value("pc_set_o", 32'(pc_set_o), 32'h0);
    check_value("id_in_ready_o", 32'(id_in_ready_o), 32'h1);
    wait_ready(TIMEOUT_CYCLES);
    read_reg(5'd13, 32'h0000_2004);
  endtask

  task automatic illegal_retire();
    word_t keep;
    word_t other;
    rand_word(keep);
    rand_word(other);
    write_reg(5'd14, keep);
    // Unknown major opcode, rd field is x14
    issue({7'h00, 5'd1, 5'd2, 3'b000, 5'd14, 7'h7f}, 32'h0000_0500, other, 1'b0);
    check_value("illegal_insn_o", 32'(illegal_insn_o), 32'h1);
    check_value("id_in_ready_o", 32'(id_in_ready_o), 32'h1);
    check_value("lsu_req_o", 32'(lsu_req_o), 32'h0);
    check_value("pc_set_o", 32'(pc_set_o), 32'h0);
    wait_ready(TIMEOUT_CYCLES);
    // JALR x14, 0(x1) is outside the supported set
    issue(i_type_word(12'h000, 5'd1, 3'b000, 5'd14, 7'h67), 32'h0000_0504, other, 1'b0);
    check_value("illegal_insn_o", 32'(illegal_insn_o), 32'h1);
    check_value("id_in_ready_o", 32'(id_in_ready_o), 32'h1);
    wait_ready(TIMEOUT_CYCLES);
    read_reg(5'd14, keep);
  endtask

  initial begin
    clk_i             = 1'b0;
    rst_ni            = 1'b0;
    instr_valid_i     = 1'b0;
    instr_rdata_i     = '0;
    pc_id_i           = '0;
    branch_decision_i = 1'b0;
    result_ex_i       = '0;
    lsu_resp_valid_i  = 1'b0;
    lfsr_q            = 32'd52;
    error_count       = 0;

    apply_reset();
    write_read_back();
    zero_register();
    load_store_stall();
    branch_sequence();
    jal_link();
    illegal_retire();

    if (error_count == 0) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      stop_with_failure("Checks failed during the run");
    end
  end

endmodule
